//--- natv_periph.f
rtl/natv_pkg.sv
rtl/natv_decoder.sv
rtl/natv_gpio.sv
rtl/natv_timer.sv
rtl/natv_uart_tx.sv
rtl/natv_periph_top.sv
verif/natv_periph_checker.sv
verif/natv_periph_tb.sv

//--- rtl/natv_decoder.sv
// register window decoder for the native bus
// steers each request to one device, merges the replies and
// answers unmapped addresses with zero data after the usual latency
`timescale 1ns/1ps

module natv_decoder (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  natv_pkg::natv_req_t req_i,
  output natv_pkg::natv_rsp_t rsp_o,
  output natv_pkg::natv_req_t gpio_req_o,
  output natv_pkg::natv_req_t uart_req_o,
  output natv_pkg::natv_req_t tim0_req_o,
  output natv_pkg::natv_req_t tim1_req_o,
  input  natv_pkg::natv_rsp_t gpio_rsp_i,
  input  natv_pkg::natv_rsp_t uart_rsp_i,
  input  natv_pkg::natv_rsp_t tim0_rsp_i,
  input  natv_pkg::natv_rsp_t tim1_rsp_i
);
  import natv_pkg::*;

  natv_dev_e s_dev;
  logic      s_none_sel;
  logic      none_rdy_q;
  logic      s_gpio_hit;
  logic      s_uart_hit;
  logic      s_tim0_hit;
  logic      s_tim1_hit;
  logic      s_none_hit;

  // window match first, then the device byte
  always_comb begin
    s_dev = DEV_NONE;
    if (req_i.addr[31:24] == NATV_PERIPH_BASE) begin
      case (req_i.addr[15:8])
        NATV_OFS_GPIO: s_dev = DEV_GPIO;
        NATV_OFS_UART: s_dev = DEV_UART;
        NATV_OFS_TIM0: s_dev = DEV_TIM0;
        NATV_OFS_TIM1: s_dev = DEV_TIM1;
        default:       s_dev = DEV_NONE;
      endcase
    end
  end

  // only valid is gated, the payload goes to every device
  always_comb begin
    gpio_req_o       = req_i;
    uart_req_o       = req_i;
    tim0_req_o       = req_i;
    tim1_req_o       = req_i;
    gpio_req_o.valid = req_i.valid && (s_dev == DEV_GPIO);
    uart_req_o.valid = req_i.valid && (s_dev == DEV_UART);
    tim0_req_o.valid = req_i.valid && (s_dev == DEV_TIM0);
    tim1_req_o.valid = req_i.valid && (s_dev == DEV_TIM1);
  end

  assign s_none_sel = req_i.valid && (s_dev == DEV_NONE);

  // unmapped reply, same one-cycle latency as a device
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      none_rdy_q <= 1'b0;
    end else begin
      none_rdy_q <= s_none_sel && !none_rdy_q;
    end
  end

  assign s_gpio_hit = gpio_req_o.valid & gpio_rsp_i.ready;
  assign s_uart_hit = uart_req_o.valid & uart_rsp_i.ready;
  assign s_tim0_hit = tim0_req_o.valid & tim0_rsp_i.ready;
  assign s_tim1_hit = tim1_req_o.valid & tim1_rsp_i.ready;
  assign s_none_hit = s_none_sel & none_rdy_q;

  // unmapped reads contribute no data, so rdata stays zero for them
  assign rsp_o.ready = s_gpio_hit | s_uart_hit | s_tim0_hit | s_tim1_hit | s_none_hit;
  assign rsp_o.rdata = ({32{s_gpio_hit}} & gpio_rsp_i.rdata) |
                       ({32{s_uart_hit}} & uart_rsp_i.rdata) |
                       ({32{s_tim0_hit}} & tim0_rsp_i.rdata) |
                       ({32{s_tim1_hit}} & tim1_rsp_i.rdata);

endmodule

//--- rtl/natv_gpio.sv
// GPIO block on the native bus
// DIR drives the output enables, OUT the pin levels, IN reads the
// synchronized pins; writes follow the byte strobes
`timescale 1ns/1ps

module natv_gpio #(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  natv_pkg::natv_req_t   req_i,
  output natv_pkg::natv_rsp_t   rsp_o,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o
);
  import natv_pkg::*;

  logic                  ready_q;
  logic                  s_wr;
  logic [31:0]           s_mask;
  logic [31:0]           s_dir_new;
  logic [31:0]           s_out_new;
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] in_meta_q;
  logic [GPIO_WIDTH-1:0] in_sync_q;

  assign s_wr   = req_i.valid && ready_q && (req_i.wstrb != 4'b0000);
  // expand strobes to a bit mask
  assign s_mask = {{8{req_i.wstrb[3]}}, {8{req_i.wstrb[2]}},
                   {8{req_i.wstrb[1]}}, {8{req_i.wstrb[0]}}};

  assign s_dir_new = (32'(dir_q) & ~s_mask) | (req_i.wdata & s_mask);
  assign s_out_new = (32'(out_q) & ~s_mask) | (req_i.wdata & s_mask);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      dir_q   <= '0;
      out_q   <= '0;
    end else begin
      ready_q <= req_i.valid && !ready_q;
      if (s_wr && req_i.addr[7:0] == NATV_GPIO_DIR) dir_q <= s_dir_new[GPIO_WIDTH-1:0];
      if (s_wr && req_i.addr[7:0] == NATV_GPIO_OUT) out_q <= s_out_new[GPIO_WIDTH-1:0];
    end
  end

  // two-flop synchronizer on the input pins
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  always_comb begin
    rsp_o.ready = ready_q;
    case (req_i.addr[7:0])
      NATV_GPIO_DIR: rsp_o.rdata = 32'(dir_q);
      NATV_GPIO_OUT: rsp_o.rdata = 32'(out_q);
      NATV_GPIO_IN:  rsp_o.rdata = 32'(in_sync_q);
      default:       rsp_o.rdata = 32'h0;
    endcase
  end

  assign gpio_oe_o  = dir_q;
  assign gpio_out_o = out_q;

endmodule

//--- rtl/natv_periph_top.sv
// peripheral subsystem top on the processor's native bus
// decoder plus GPIO, UART transmitter and two timers
// irq_o: bit 0 UART, bit 1 timer 0, bit 2 timer 1
`timescale 1ns/1ps

module natv_periph_top #(
  parameter int          GPIO_WIDTH     = 8,
  parameter int unsigned UART_DIV_RESET = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  natv_pkg::natv_req_t   req_i,
  output natv_pkg::natv_rsp_t   rsp_o,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                  uart_tx_o,
  output logic [2:0]            irq_o
);
  import natv_pkg::*;

  natv_req_t gpio_req;
  natv_req_t uart_req;
  natv_req_t tim0_req;
  natv_req_t tim1_req;
  natv_rsp_t gpio_rsp;
  natv_rsp_t uart_rsp;
  natv_rsp_t tim0_rsp;
  natv_rsp_t tim1_rsp;

  natv_decoder u_decoder (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .rsp_o     (rsp_o),
    .gpio_req_o(gpio_req),
    .uart_req_o(uart_req),
    .tim0_req_o(tim0_req),
    .tim1_req_o(tim1_req),
    .gpio_rsp_i(gpio_rsp),
    .uart_rsp_i(uart_rsp),
    .tim0_rsp_i(tim0_rsp),
    .tim1_rsp_i(tim1_rsp)
  );

  natv_gpio #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) u_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (gpio_req),
    .rsp_o     (gpio_rsp),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o)
  );

  natv_uart_tx #(
    .UART_DIV_RESET(UART_DIV_RESET)
  ) u_uart_tx (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (uart_req),
    .rsp_o  (uart_rsp),
    .tx_o   (uart_tx_o),
    .irq_o  (irq_o[0])
  );

  natv_timer u_timer0 (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (tim0_req),
    .rsp_o  (tim0_rsp),
    .irq_o  (irq_o[1])
  );

  natv_timer u_timer1 (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (tim1_req),
    .rsp_o  (tim1_rsp),
    .irq_o  (irq_o[2])
  );

endmodule

//--- rtl/natv_pkg.sv
// shared types and constants for the native bus peripheral subsystem
// modules import this inside their body and use scoped names in port lists
package natv_pkg;

  // one bus request, held stable by the master until ready
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } natv_req_t;

  // ready is a single-cycle pulse, rdata valid alongside it
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } natv_rsp_t;

  // decoded target of the current request
  typedef enum logic [2:0] {
    DEV_GPIO,
    DEV_UART,
    DEV_TIM0,
    DEV_TIM1,
    DEV_NONE
  } natv_dev_e;

  // addr[31:24] of the register window
  localparam logic [7:0] NATV_PERIPH_BASE = 8'h10;

  // device select, compared against addr[15:8]
  localparam logic [7:0] NATV_OFS_GPIO = 8'h00;
  localparam logic [7:0] NATV_OFS_UART = 8'h10;
  localparam logic [7:0] NATV_OFS_TIM0 = 8'h20;
  localparam logic [7:0] NATV_OFS_TIM1 = 8'h30;

  // register offsets, compared against addr[7:0]
  localparam logic [7:0] NATV_GPIO_DIR  = 8'h00;
  localparam logic [7:0] NATV_GPIO_OUT  = 8'h04;
  localparam logic [7:0] NATV_GPIO_IN   = 8'h08;
  localparam logic [7:0] NATV_UART_DATA = 8'h00;
  localparam logic [7:0] NATV_UART_DIV  = 8'h04;
  localparam logic [7:0] NATV_UART_STAT = 8'h08;
  localparam logic [7:0] NATV_TIM_CTRL  = 8'h00;
  localparam logic [7:0] NATV_TIM_CMP   = 8'h04;
  localparam logic [7:0] NATV_TIM_CNT   = 8'h08;
  localparam logic [7:0] NATV_TIM_STAT  = 8'h0C;

endpackage

//--- rtl/natv_timer.sv
// compare-match timer on the native bus
// CTRL bit 0 runs the counter, bit 1 enables the interrupt; when CNT
// reaches CMP it wraps to zero and sets the sticky match flag in STAT
`timescale 1ns/1ps

module natv_timer (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  natv_pkg::natv_req_t req_i,
  output natv_pkg::natv_rsp_t rsp_o,
  output logic                irq_o
);
  import natv_pkg::*;

  logic        ready_q;
  logic        s_wr;
  logic        s_match;
  logic [1:0]  ctrl_q;
  logic [31:0] cmp_q;
  logic [31:0] cnt_q;
  logic        match_q;

  assign s_wr    = req_i.valid && ready_q && (req_i.wstrb != 4'b0000);
  assign s_match = ctrl_q[0] && (cnt_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      ctrl_q  <= 2'b00;
      cmp_q   <= 32'h0;
      cnt_q   <= 32'h0;
      match_q <= 1'b0;
    end else begin
      ready_q <= req_i.valid && !ready_q;

      if (s_wr && req_i.addr[7:0] == NATV_TIM_CTRL) ctrl_q <= req_i.wdata[1:0];
      if (s_wr && req_i.addr[7:0] == NATV_TIM_CMP) cmp_q <= req_i.wdata;

      // counter wraps in the cycle it equals the compare value
      if (s_match) begin
        cnt_q <= 32'h0;
      end else if (ctrl_q[0]) begin
        cnt_q <= cnt_q + 32'd1;
      end

      // write-one-to-clear, a new match in the same cycle wins
      if (s_wr && req_i.addr[7:0] == NATV_TIM_STAT && req_i.wdata[0]) begin
        match_q <= 1'b0;
      end
      if (s_match) begin
        match_q <= 1'b1;
      end
    end
  end

  always_comb begin
    rsp_o.ready = ready_q;
    case (req_i.addr[7:0])
      NATV_TIM_CTRL: rsp_o.rdata = {30'h0, ctrl_q};
      NATV_TIM_CMP:  rsp_o.rdata = cmp_q;
      NATV_TIM_CNT:  rsp_o.rdata = cnt_q;
      NATV_TIM_STAT: rsp_o.rdata = {31'h0, match_q};
      default:       rsp_o.rdata = 32'h0;
    endcase
  end

  assign irq_o = match_q & ctrl_q[1];

endmodule

//--- rtl/natv_uart_tx.sv
// transmit-only 8N1 UART on the native bus
// a DATA write while idle sends one frame, each bit lasting DIV clocks;
// STAT bit 0 is busy, bit 1 the done flag that also drives the interrupt
`timescale 1ns/1ps

module natv_uart_tx #(
  parameter int unsigned UART_DIV_RESET = 16
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  natv_pkg::natv_req_t req_i,
  output natv_pkg::natv_rsp_t rsp_o,
  output logic                tx_o,
  output logic                irq_o
);
  import natv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } state_e;

  state_e      state_q;
  logic        ready_q;
  logic        s_wr;
  logic        s_start;
  logic        s_bit_end;
  logic        s_busy;
  logic [15:0] div_q;
  logic [15:0] div_cnt_q;
  logic [2:0]  bit_cnt_q;
  logic [7:0]  shift_q;
  logic        tx_q;
  logic        done_q;

  assign s_wr      = req_i.valid && ready_q && (req_i.wstrb != 4'b0000);
  assign s_busy    = (state_q != IDLE);
  assign s_start   = s_wr && (req_i.addr[7:0] == NATV_UART_DATA) && !s_busy;
  // a divisor of zero behaves like one
  assign s_bit_end = (div_cnt_q + 16'd1 >= div_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      ready_q   <= 1'b0;
      div_q     <= 16'(UART_DIV_RESET);
      div_cnt_q <= 16'h0;
      bit_cnt_q <= 3'd0;
      tx_q      <= 1'b1;
      done_q    <= 1'b0;
    end else begin
      ready_q <= req_i.valid && !ready_q;
      if (s_wr && req_i.addr[7:0] == NATV_UART_DIV) div_q <= req_i.wdata[15:0];
      if (s_wr && req_i.addr[7:0] == NATV_UART_STAT && req_i.wdata[1]) done_q <= 1'b0;

      div_cnt_q <= (state_q == IDLE || s_bit_end) ? 16'h0 : div_cnt_q + 16'd1;

      case (state_q)
        IDLE: begin
          if (s_start) begin
            state_q <= START;
            tx_q    <= 1'b0;
          end
        end
        START: begin
          if (s_bit_end) begin
            state_q   <= DATA;
            bit_cnt_q <= 3'd0;
            tx_q      <= shift_q[0];
          end
        end
        DATA: begin
          if (s_bit_end) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            tx_q      <= shift_q[1];
            if (bit_cnt_q == 3'd7) begin
              state_q <= STOP;
              tx_q    <= 1'b1;
            end
          end
        end
        STOP: begin
          if (s_bit_end) begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // shift register is payload, loaded on start and shifted per data bit
  always_ff @(posedge clk_i) begin
    if (s_start) begin
      shift_q <= req_i.wdata[7:0];
    end else if (state_q == DATA && s_bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  always_comb begin
    rsp_o.ready = ready_q;
    case (req_i.addr[7:0])
      NATV_UART_DIV:  rsp_o.rdata = {16'h0, div_q};
      NATV_UART_STAT: rsp_o.rdata = {30'h0, done_q, s_busy};
      default:        rsp_o.rdata = 32'h0;
    endcase
  end

  assign tx_o  = tx_q;
  assign irq_o = done_q;

endmodule

//--- verif/natv_periph_checker.sv
// protocol and reset assertions on the peripheral top level ports
// bound into every natv_periph_top instance, reports only through $error
`timescale 1ns/1ps

module natv_periph_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input natv_pkg::natv_req_t req_i,
  input natv_pkg::natv_rsp_t rsp_o,
  input logic [2:0]          irq_o,
  input logic                uart_tx_o
);
  import natv_pkg::*;

  // a reply comes only after the request has been held for a cycle
  ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.ready |-> req_i.valid && $past(req_i.valid)
  ) else $error("bus ready seen without a request held since the previous cycle");

  // ready is a one-cycle pulse
  ready_single_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.ready |=> !rsp_o.ready
  ) else $error("bus ready held high for two cycles");

  // quiet outputs right after reset release
  reset_outputs_idle: assert property (
    @(posedge clk_i)
    $rose(rst_n_i) |-> (irq_o == 3'b000) && uart_tx_o
  ) else $error("interrupts or serial line not idle after reset");

endmodule

bind natv_periph_top natv_periph_checker u_checker (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .req_i    (req_i),
  .rsp_o    (rsp_o),
  .irq_o    (irq_o),
  .uart_tx_o(uart_tx_o)
);

//--- verif/natv_periph_tb.sv
// table-driven testbench for the native bus peripheral subsystem
// rows are bus writes, reads, polls, waits and pin checks applied in order;
// a line monitor decodes each UART frame on uart_tx_o
`timescale 1ns/1ps

module natv_periph_tb;
  import natv_pkg::*;

  localparam int GPIO_WIDTH     = 8;
  localparam int UART_DIV_RESET = 16;
  localparam int MAX_CYCLES     = 4000;
  localparam int POLL_LIMIT     = 200;

  // pin groups selected by the address field of a pin check row
  localparam logic [31:0] PIN_OE     = 32'd0;
  localparam logic [31:0] PIN_OUT    = 32'd1;
  localparam logic [31:0] PIN_IRQ    = 32'd2;
  localparam logic [31:0] PIN_FRAMES = 32'd3;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_RDLE, OP_POLL, OP_WAIT, OP_DRV, OP_PIN} op_e;

  // for writes the mask field carries the byte strobes
  typedef struct {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] mask;
  } row_t;

  logic                  clk_i;
  logic                  rst_n_i;
  natv_req_t             req_i;
  natv_rsp_t             rsp_o;
  logic [GPIO_WIDTH-1:0] gpio_in_i;
  logic [GPIO_WIDTH-1:0] gpio_out_o;
  logic [GPIO_WIDTH-1:0] gpio_oe_o;
  logic                  uart_tx_o;
  logic [2:0]            irq_o;

  row_t        tbl[$];
  logic [31:0] lfsr_q;
  int          errors;
  int          checks;
  int          cycles;
  int          frames;
  int          mon_div;
  logic [7:0]  uart_exp;

  natv_periph_top #(
    .GPIO_WIDTH    (GPIO_WIDTH),
    .UART_DIV_RESET(UART_DIV_RESET)
  ) uut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .rsp_o     (rsp_o),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o),
    .uart_tx_o (uart_tx_o),
    .irq_o     (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [7:0] dev, input logic [7:0] ofs);
    return {NATV_PERIPH_BASE, 8'h00, dev, ofs};
  endfunction

  task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] exp, input logic [31:0] mask);
    row_t r;
    r = '{op, addr, data, exp, mask};
    tbl.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] dir_v;
    logic [31:0] out_v;
    logic [31:0] in_v;
    logic [31:0] out2_v;
    logic [31:0] byte_v;
    lfsr_q = 32'hc37a3777;
    dir_v  = lfsr_take(GPIO_WIDTH);
    out_v  = lfsr_take(GPIO_WIDTH);
    in_v   = lfsr_take(GPIO_WIDTH);
    out2_v = lfsr_take(GPIO_WIDTH);
    byte_v = lfsr_take(8);
    // reset values
    add_row(OP_RD, reg_addr(NATV_OFS_GPIO, NATV_GPIO_DIR), 0, 0, 32'hffff_ffff);
    add_row(OP_RD, reg_addr(NATV_OFS_GPIO, NATV_GPIO_OUT), 0, 0, 32'hffff_ffff);
    add_row(OP_RD, reg_addr(NATV_OFS_UART, NATV_UART_DIV), 0, UART_DIV_RESET, 32'hffff_ffff);
    add_row(OP_RD, reg_addr(NATV_OFS_TIM0, NATV_TIM_CTRL), 0, 0, 32'hffff_ffff);
    add_row(OP_RD, reg_addr(NATV_OFS_TIM1, NATV_TIM_CTRL), 0, 0, 32'hffff_ffff);
    add_row(OP_PIN, PIN_OE, 0, 0, 32'hff);
    add_row(OP_PIN, PIN_OUT, 0, 0, 32'hff);
    add_row(OP_PIN, PIN_IRQ, 0, 0, 32'h7);
    // GPIO registers and pins
    add_row(OP_WR, reg_addr(NATV_OFS_GPIO, NATV_GPIO_DIR), dir_v, 0, 32'hf);
    add_row(OP_WR, reg_addr(NATV_OFS_GPIO, NATV_GPIO_OUT), out_v, 0, 32'hf);
    add_row(OP_PIN, PIN_OE, 0, dir_v, 32'hff);
    add_row(OP_PIN, PIN_OUT, 0, out_v, 32'hff);
    add_row(OP_RD, reg_addr(NATV_OFS_GPIO, NATV_GPIO_DIR), 0, dir_v, 32'hffff_ffff);
    add_row(OP_DRV, 0, in_v, 0, 0);
    add_row(OP_WAIT, 0, 3, 0, 0);
    add_row(OP_RD, reg_addr(NATV_OFS_GPIO, NATV_GPIO_IN), 0, in_v, 32'hffff_ffff);
    // lane 1 holds no pins, so OUT keeps its value
    add_row(OP_WR, reg_addr(NATV_OFS_GPIO, NATV_GPIO_OUT), ~out_v, 0, 32'h2);
    add_row(OP_RD, reg_addr(NATV_OFS_GPIO, NATV_GPIO_OUT), 0, out_v, 32'hffff_ffff);
    add_row(OP_WR, reg_addr(NATV_OFS_GPIO, NATV_GPIO_OUT), {24'hffffff, out2_v[7:0]}, 0, 32'h1);
    add_row(OP_RD, reg_addr(NATV_OFS_GPIO, NATV_GPIO_OUT), 0, out2_v, 32'hffff_ffff);
    add_row(OP_PIN, PIN_OUT, 0, out2_v, 32'hff);
    // timer 0 compare match
    add_row(OP_WR, reg_addr(NATV_OFS_TIM0, NATV_TIM_CMP), 20, 0, 32'hf);
    add_row(OP_WR, reg_addr(NATV_OFS_TIM0, NATV_TIM_CTRL), 3, 0, 32'hf);
    add_row(OP_POLL, reg_addr(NATV_OFS_TIM0, NATV_TIM_STAT), 0, 1, 32'h1);
    add_row(OP_PIN, PIN_IRQ, 0, 32'h2, 32'h2);
    add_row(OP_RDLE, reg_addr(NATV_OFS_TIM0, NATV_TIM_CNT), 0, 20, 0);
    add_row(OP_RDLE, reg_addr(NATV_OFS_TIM0, NATV_TIM_CNT), 0, 20, 0);
    // stop counting with the interrupt still enabled so the clear shows on irq_o
    add_row(OP_WR, reg_addr(NATV_OFS_TIM0, NATV_TIM_CTRL), 2, 0, 32'hf);
    add_row(OP_WR, reg_addr(NATV_OFS_TIM0, NATV_TIM_STAT), 1, 0, 32'hf);
    add_row(OP_RD, reg_addr(NATV_OFS_TIM0, NATV_TIM_STAT), 0, 0, 32'h1);
    add_row(OP_PIN, PIN_IRQ, 0, 0, 32'h7);
    add_row(OP_RD, reg_addr(NATV_OFS_TIM1, NATV_TIM_STAT), 0, 0, 32'hffff_ffff);
    add_row(OP_RD, reg_addr(NATV_OFS_TIM1, NATV_TIM_CNT), 0, 0, 32'hffff_ffff);
    // UART frame at DIV=4
    add_row(OP_WR, reg_addr(NATV_OFS_UART, NATV_UART_DIV), 4, 0, 32'hf);
    add_row(OP_WR, reg_addr(NATV_OFS_UART, NATV_UART_DATA), byte_v, 0, 32'hf);
    add_row(OP_RD, reg_addr(NATV_OFS_UART, NATV_UART_STAT), 0, 1, 32'h1);
    add_row(OP_POLL, reg_addr(NATV_OFS_UART, NATV_UART_STAT), 0, 2, 32'h3);
    add_row(OP_PIN, PIN_IRQ, 0, 1, 32'h7);
    add_row(OP_PIN, PIN_FRAMES, 0, 1, 32'hffff_ffff);
    add_row(OP_WR, reg_addr(NATV_OFS_UART, NATV_UART_STAT), 2, 0, 32'hf);
    add_row(OP_RD, reg_addr(NATV_OFS_UART, NATV_UART_STAT), 0, 0, 32'h3);
    add_row(OP_PIN, PIN_IRQ, 0, 0, 32'h7);
    // unmapped space reads zero and swallows writes
    add_row(OP_RD, 32'h1000_9000, 0, 0, 32'hffff_ffff);
    add_row(OP_RD, 32'h2000_0000, 0, 0, 32'hffff_ffff);
    add_row(OP_WR, 32'h2000_0004, ~out2_v, 0, 32'hf);
    add_row(OP_WR, 32'h1000_9004, ~out2_v, 0, 32'hf);
    add_row(OP_RD, reg_addr(NATV_OFS_GPIO, NATV_GPIO_OUT), 0, out2_v, 32'hffff_ffff);
    add_row(OP_RD, reg_addr(NATV_OFS_GPIO, NATV_GPIO_DIR), 0, dir_v, 32'hffff_ffff);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                          input string what, input logic [31:0] addr);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s 0x%08h gave 0x%08h, expected 0x%08h",
               $time, what, addr, got, exp);
    end
  endtask

  // one access, held until ready, released on the edge that ends the ready cycle
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [31:0] rdata);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    rdata  = '0;
    @(posedge clk_i);
    req_i <= {1'b1, addr, data, strb};
    while (!seen && waited < 20) begin
      @(negedge clk_i);
      waited++;
      if (rsp_o.ready) begin
        seen  = 1'b1;
        rdata = rsp_o.rdata;
      end
    end
    if (!seen) begin
      errors++;
      $display("bus access to 0x%08h got no ready within 20 cycles", addr);
    end
    @(posedge clk_i);
    req_i <= '0;
  endtask

  task automatic run_row(input row_t r);
    logic [31:0] rd;
    logic [31:0] got;
    int          tries;
    case (r.op)
      OP_WR: begin
        if (r.addr == reg_addr(NATV_OFS_UART, NATV_UART_DIV)) mon_div = r.data;
        if (r.addr == reg_addr(NATV_OFS_UART, NATV_UART_DATA)) uart_exp = r.data[7:0];
        bus_access(r.addr, r.data, r.mask[3:0], rd);
      end
      OP_RD: begin
        bus_access(r.addr, 32'h0, 4'h0, rd);
        check_eq(rd & r.mask, r.exp & r.mask, "read", r.addr);
      end
      OP_RDLE: begin
        bus_access(r.addr, 32'h0, 4'h0, rd);
        checks++;
        if (rd > r.exp) begin
          errors++;
          $display("** Error at %0t: count 0x%08h above limit %0d", $time, rd, r.exp);
        end
      end
      OP_POLL: begin
        tries = 0;
        rd    = '0;
        while (tries < POLL_LIMIT && (rd & r.mask) != r.exp) begin
          bus_access(r.addr, 32'h0, 4'h0, rd);
          tries++;
        end
        checks++;
        if ((rd & r.mask) != r.exp) begin
          errors++;
          $display("polling 0x%08h never reached the expected status", r.addr);
        end
      end
      OP_WAIT: repeat (r.data) @(posedge clk_i);
      OP_DRV: begin
        @(posedge clk_i);
        gpio_in_i <= r.data[GPIO_WIDTH-1:0];
      end
      OP_PIN: begin
        @(negedge clk_i);
        case (r.addr)
          PIN_OE:  got = 32'(gpio_oe_o);
          PIN_OUT: got = 32'(gpio_out_o);
          PIN_IRQ: got = 32'(irq_o);
          default: got = 32'(frames);
        endcase
        check_eq(got & r.mask, r.exp & r.mask, "pin group", r.addr);
      end
      default: ;
    endcase
  endtask

  // serial line monitor, samples each bit near its middle
  initial begin
    logic [7:0] got_byte;
    forever begin
      @(negedge uart_tx_o);
      if (rst_n_i) begin
        repeat (mon_div / 2) @(negedge clk_i);
        if (uart_tx_o !== 1'b0) begin
          errors++;
          $display("start bit on the UART line was too short");
        end
        for (int i = 0; i < 8; i++) begin
          repeat (mon_div) @(negedge clk_i);
          got_byte[i] = uart_tx_o;
        end
        repeat (mon_div) @(negedge clk_i);
        if (uart_tx_o !== 1'b1) begin
          errors++;
          $display("stop bit missing on the UART line");
        end
        check_eq(32'(got_byte), 32'(uart_exp), "uart byte", 32'h0);
        frames++;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("run stopped after %0d cycles without reaching the end of the table", cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    rst_n_i   = 1'b0;
    req_i     = '0;
    gpio_in_i = '0;
    errors    = 0;
    checks    = 0;
    frames    = 0;
    mon_div   = UART_DIV_RESET;
    uart_exp  = 8'h00;
    build_table();
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    foreach (tbl[i]) begin
      run_row(tbl[i]);
    end
    repeat (4) @(posedge clk_i);
    $display("rows %0d, checks %0d, errors %0d", tbl.size(), checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
